// File: Bender.yml
package:
  name: conv3x3_layer

sources:
  - conv_pkg.sv
  - line_buffer.sv
  - conv_ctrl.sv
  - weight_ram.sv
  - mac_array.sv
  - output_collector.sv
  - conv3x3_layer.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_conv3x3_layer.sv

// File: compile.f
conv_pkg.sv
line_buffer.sv
conv_ctrl.sv
weight_ram.sv
mac_array.sv
output_collector.sv
conv3x3_layer.sv
tb_clock_gen.sv
tb_conv3x3_layer.sv

// File: conv3x3_layer.sv
`timescale 1ns/100ps
`default_nettype none

module conv3x3_layer import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  pixel_t     in_pixel,
    input  weight_wr_t weight_wr,
    output logic       busy,
    output logic       out_valid,
    output feature_t   out_feature
);

    window_t                 window;
    window_t                 win_latched;
    logic [OCH_W-1:0]        och;
    weights_t                weights;
    mac_tag_t                ctrl_tag;
    mac_tag_t                mac_tag;
    logic signed [ACC_W-1:0] mac_sum;

    // ==================================================
    // Window generation and control
    // ==================================================
    line_buffer u_line_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (in_valid),
        .in_pixel (in_pixel),
        .window   (window)
    );

    conv_ctrl u_conv_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (in_valid),
        .window      (window),
        .busy        (busy),
        .win_latched (win_latched),
        .och         (och),
        .tag         (ctrl_tag)
    );

    // ==================================================
    // Folded datapath
    // ==================================================
    weight_ram u_weight_ram (
        .clk       (clk),
        .weight_wr (weight_wr),
        .och       (och),
        .weights   (weights)
    );

    mac_array u_mac_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .window  (win_latched),
        .weights (weights),
        .tag_in  (ctrl_tag),
        .sum     (mac_sum),
        .tag_out (mac_tag)
    );

    output_collector u_output_collector (
        .clk         (clk),
        .rst_n       (rst_n),
        .sum         (mac_sum),
        .tag         (mac_tag),
        .out_valid   (out_valid),
        .out_feature (out_feature)
    );

endmodule

`default_nettype wire

// File: conv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl import conv_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             accept,
    input  window_t          window,
    output logic             busy,
    output window_t          win_latched,
    output logic [OCH_W-1:0] och,
    output mac_tag_t         tag
);

    typedef enum logic {
        S_IDLE,
        S_CALC
    } state_t;

    state_t           state_q;
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic [OCH_W-1:0] och_q;
    logic             win_ready;
    logic             trig_q;
    logic             start;
    logic             och_last;
    mac_tag_t         tag_q;

    // ==================================================
    // Position counters
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            if (col_q == COL_W'(IMG_W - 1)) begin
                col_q <= '0;
                row_q <= (row_q == ROW_W'(IMG_H - 1)) ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // Valid convolution only, so the window is full from row 2 / col 2
    assign win_ready = accept && (row_q >= ROW_W'(KSIZE - 1)) && (col_q >= COL_W'(KSIZE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= win_ready;
        end
    end

    assign start    = trig_q && (state_q == S_IDLE);
    assign och_last = (och_q == OCH_W'(CH_OUT - 1));

    always_ff @(posedge clk) begin
        if (start) begin
            win_latched <= window;
        end
    end

    // ==================================================
    // Channel fold FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            och_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    och_q <= '0;
                    if (start) begin
                        state_q <= S_CALC;
                    end
                end
                S_CALC: begin
                    if (och_last) begin
                        state_q <= S_IDLE;
                        och_q   <= '0;
                    end else begin
                        och_q <= och_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Tag lags the channel index by one cycle, in step with the weight read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q.valid <= (state_q == S_CALC);
            tag_q.och   <= och_q;
            tag_q.last  <= (state_q == S_CALC) && och_last;
        end
    end

    assign busy = (state_q == S_CALC);
    assign och  = och_q;
    assign tag  = tag_q;

    // Upstream holds off while folding
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(accept && busy));

    // A completed window must never arrive while the previous one still folds
    a_no_lost_window: assert property (@(posedge clk) disable iff (!rst_n)
        trig_q |-> state_q == S_IDLE);

endmodule

`default_nettype wire

// File: conv_pkg.sv
`default_nettype none

package conv_pkg;

    // ==================================================
    // Frame and layer sizes
    // ==================================================
    localparam int IMG_W       = 5;
    localparam int IMG_H       = 5;
    localparam int CH_IN       = 2;
    localparam int CH_OUT      = 4;
    localparam int KSIZE       = 3;
    localparam int QUANT_SHIFT = 4;
    localparam int PIX_W       = 8;
    localparam int ACC_W       = 24;

    // Derived index widths
    localparam int OCH_W = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;
    localparam int ICH_W = (CH_IN > 1) ? $clog2(CH_IN) : 1;
    localparam int TAP_W = $clog2(KSIZE * KSIZE);
    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);

    // Signed byte range for requantization
    localparam int Q_MAX = 2 ** (PIX_W - 1) - 1;
    localparam int Q_MIN = -(2 ** (PIX_W - 1));

    // ==================================================
    // Data types
    // ==================================================
    typedef logic signed [PIX_W-1:0] sbyte_t;
    typedef sbyte_t [CH_IN-1:0] pixel_t;

    // Indexed [row][col], row 0 and col 0 are the oldest
    typedef pixel_t [KSIZE-1:0][KSIZE-1:0] window_t;
    typedef sbyte_t [KSIZE-1:0][KSIZE-1:0][CH_IN-1:0] weights_t;
    typedef sbyte_t [CH_OUT-1:0] feature_t;

    typedef struct packed {
        logic             en;
        logic [OCH_W-1:0] och;
        logic [ICH_W-1:0] ich;
        logic [TAP_W-1:0] tap;
        sbyte_t           value;
    } weight_wr_t;

    // Travels beside the MAC datapath
    typedef struct packed {
        logic             valid;
        logic [OCH_W-1:0] och;
        logic             last;
    } mac_tag_t;

endpackage

`default_nettype wire

// File: conv_trace.txt
# W och ich tap0..tap8 | P frame ch0 ch1 | E frame och0..och3
# Frames in raster order, expected outputs one per valid position
W 0 0 0 0 0 0 16 0 0 0 0
W 0 1 0 0 0 0 0 0 0 0 0
W 1 0 0 0 0 0 0 0 0 0 0
W 1 1 1 1 1 1 1 1 1 1 1
W 2 0 32 0 0 0 0 0 0 0 0
W 2 1 0 0 0 0 0 0 0 0 -32
W 3 0 -16 -16 -16 -16 -16 -16 -16 -16 -16
W 3 1 0 0 0 0 0 0 0 0 0
P 0 0 0
P 0 1 1
P 0 2 2
P 0 3 3
P 0 4 4
P 0 5 -1
P 0 6 0
P 0 7 1
P 0 8 2
P 0 9 3
P 0 10 -2
P 0 11 -1
P 0 12 0
P 0 13 1
P 0 14 2
P 0 15 -3
P 0 16 -2
P 0 17 -1
P 0 18 0
P 0 19 1
P 0 20 -4
P 0 21 -3
P 0 22 -2
P 0 23 -1
P 0 24 0
E 0 6 0 0 -54
E 0 7 0 0 -63
E 0 8 1 0 -72
E 0 11 -1 12 -99
E 0 12 0 12 -108
E 0 13 0 12 -117
E 0 16 -2 24 -128
E 0 17 -1 24 -128
E 0 18 0 24 -128
P 1 100 -100
P 1 101 -100
P 1 102 -100
P 1 103 -100
P 1 104 -100
P 1 100 -101
P 1 101 -101
P 1 102 -101
P 1 103 -101
P 1 104 -101
P 1 100 -102
P 1 101 -102
P 1 102 -102
P 1 103 -102
P 1 104 -102
P 1 100 -103
P 1 101 -103
P 1 102 -103
P 1 103 -103
P 1 104 -103
P 1 100 -104
P 1 101 -104
P 1 102 -104
P 1 103 -104
P 1 104 -104
E 1 101 -57 127 -128
E 1 102 -57 127 -128
E 1 103 -57 127 -128
E 1 101 -58 127 -128
E 1 102 -58 127 -128
E 1 103 -58 127 -128
E 1 101 -58 127 -128
E 1 102 -58 127 -128
E 1 103 -58 127 -128

// File: line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module line_buffer import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    accept,
    input  pixel_t  in_pixel,
    output window_t window
);

    // Index 0 is the newest pixel, IMG_W-1 the one a full row back
    pixel_t [IMG_W-1:0] row1_q;
    pixel_t [IMG_W-1:0] row0_q;
    pixel_t [KSIZE-1:0] new_col;
    window_t            win_q;

    // ==================================================
    // Row stores
    // ==================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            row1_q <= {row1_q[IMG_W-2:0], in_pixel};
            row0_q <= {row0_q[IMG_W-2:0], row1_q[IMG_W-1]};
        end
    end

    // Column entering the window, oldest row first
    assign new_col[0] = row0_q[IMG_W-1];
    assign new_col[1] = row1_q[IMG_W-1];
    assign new_col[2] = in_pixel;

    // ==================================================
    // 3x3 window shift register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_q <= '0;
        end else if (accept) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int c = 0; c < KSIZE - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][KSIZE-1] <= new_col[r];
            end
        end
    end

    assign window = win_q;

endmodule

`default_nettype wire

// File: mac_array.sv
`timescale 1ns/100ps
`default_nettype none

module mac_array import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  window_t                 window,
    input  weights_t                weights,
    input  mac_tag_t                tag_in,
    output logic signed [ACC_W-1:0] sum,
    output mac_tag_t                tag_out
);

    logic signed [ACC_W-1:0] dot_d [CH_IN];
    logic signed [ACC_W-1:0] dot_q [CH_IN];
    logic signed [ACC_W-1:0] sum_d;
    logic signed [ACC_W-1:0] sum_q;
    mac_tag_t                tag1_q;
    mac_tag_t                tag2_q;

    // ==================================================
    // Stage 1 per input channel 3x3 dot product
    // ==================================================
    always_comb begin
        for (int i = 0; i < CH_IN; i++) begin
            dot_d[i] = '0;
            for (int r = 0; r < KSIZE; r++) begin
                for (int c = 0; c < KSIZE; c++) begin
                    dot_d[i] = dot_d[i]
                             + $signed(window[r][c][i]) * $signed(weights[r][c][i]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        dot_q <= dot_d;
    end

    // ==================================================
    // Stage 2 adder tree across channels
    // ==================================================
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < CH_IN; i++) begin
            sum_d = sum_d + dot_q[i];
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= sum_d;
    end

    // Tag follows the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag1_q <= '0;
            tag2_q <= '0;
        end else begin
            tag1_q <= tag_in;
            tag2_q <= tag1_q;
        end
    end

    assign sum     = sum_q;
    assign tag_out = tag2_q;

endmodule

`default_nettype wire

// File: output_collector.sv
`timescale 1ns/100ps
`default_nettype none

module output_collector import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic signed [ACC_W-1:0] sum,
    input  mac_tag_t                tag,
    output logic                    out_valid,
    output feature_t                out_feature
);

    logic signed [ACC_W-1:0] shifted;
    sbyte_t                  quant;
    feature_t                res_q;
    feature_t                res_d;
    feature_t                feat_q;
    logic                    valid_q;
    logic [OCH_W-1:0]        exp_och_q;

    // ==================================================
    // Requantization
    // ==================================================
    assign shifted = sum >>> QUANT_SHIFT;

    always_comb begin
        if (shifted > Q_MAX) begin
            quant = sbyte_t'(Q_MAX);
        end else if (shifted < Q_MIN) begin
            quant = sbyte_t'(Q_MIN);
        end else begin
            quant = shifted[PIX_W-1:0];
        end
    end

    // Buffer with the incoming channel already in place
    always_comb begin
        res_d          = res_q;
        res_d[tag.och] = quant;
    end

    always_ff @(posedge clk) begin
        if (tag.valid) begin
            res_q <= res_d;
        end
    end

    // ==================================================
    // Output register and valid pulse
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            feat_q  <= '0;
        end else begin
            valid_q <= tag.valid && tag.last;
            if (tag.valid && tag.last) begin
                feat_q <= res_d;
            end
        end
    end

    assign out_valid   = valid_q;
    assign out_feature = feat_q;

    // Channel expected next from the fold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_och_q <= '0;
        end else if (tag.valid) begin
            exp_och_q <= tag.last ? '0 : exp_och_q + 1'b1;
        end
    end

    a_och_order: assert property (@(posedge clk) disable iff (!rst_n)
        tag.valid |-> (tag.och == exp_och_q)
                      && (tag.last == (tag.och == OCH_W'(CH_OUT - 1))));

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam real HALF_PERIOD = 2.0;
    localparam int  RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release reset on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_conv3x3_layer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_conv3x3_layer import conv_pkg::*; ();

    localparam int NPIX      = IMG_W * IMG_H;
    localparam int NOUT      = (IMG_W - KSIZE + 1) * (IMG_H - KSIZE + 1);
    localparam int LATENCY   = CH_OUT + 4;
    localparam int FRAME_LEN = NPIX + NOUT * (CH_OUT + 1);
    localparam int NWRITES   = CH_OUT * CH_IN * KSIZE * KSIZE;
    // Three frames and the weight load, doubled, plus margin
    localparam int CYCLE_LIMIT = 2 * (3 * FRAME_LEN + NWRITES) + 100;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    pixel_t     in_pixel;
    weight_wr_t weight_wr;
    logic       busy;
    logic       out_valid;
    feature_t   out_feature;

    int       wgt [CH_OUT][CH_IN][KSIZE*KSIZE];
    int       pix [2][NPIX][CH_IN];
    feature_t exp_feat [2][NOUT];
    feature_t exp_q [$];
    int       trig_q [$];
    int       cycle_cnt;
    int       errors;
    int       checks;
    int       test_errors;
    int       out_count;
    int       busy_run;
    int       busy_count;
    integer   seed;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv3x3_layer dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_pixel    (in_pixel),
        .weight_wr   (weight_wr),
        .busy        (busy),
        .out_valid   (out_valid),
        .out_feature (out_feature)
    );

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ==================================================
    // Trace reader
    // ==================================================
    task automatic read_trace();
        int    fd;
        int    n;
        int    want;
        int    f;
        int    o;
        int    i;
        int    t [KSIZE*KSIZE];
        int    e [CH_OUT];
        int    p [CH_IN];
        int    pix_idx [2];
        int    exp_idx [2];
        string line;
        fd = $fopen("conv_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open conv_trace.txt");
        end else begin
            pix_idx = '{0, 0};
            exp_idx = '{0, 0};
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n    = 0;
                want = 0;
                case (line.getc(0))
                    "W": begin
                        want = 2 + KSIZE * KSIZE;
                        n = $sscanf(line, "W %d %d %d %d %d %d %d %d %d %d %d", o, i,
                                    t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8]);
                        for (int k = 0; k < KSIZE * KSIZE; k++) begin
                            wgt[o][i][k] = t[k];
                        end
                    end
                    "P": begin
                        want = 1 + CH_IN;
                        n = $sscanf(line, "P %d %d %d", f, p[0], p[1]);
                        for (int k = 0; k < CH_IN; k++) begin
                            pix[f][pix_idx[f]][k] = p[k];
                        end
                        pix_idx[f]++;
                    end
                    "E": begin
                        want = 1 + CH_OUT;
                        n = $sscanf(line, "E %d %d %d %d %d", f, e[0], e[1], e[2], e[3]);
                        for (int k = 0; k < CH_OUT; k++) begin
                            exp_feat[f][exp_idx[f]][k] = 8'(e[k]);
                        end
                        exp_idx[f]++;
                    end
                    default: begin
                        errors++;
                        $display("unknown trace line: %s", line);
                    end
                endcase
                if (n != want) begin
                    errors++;
                    $display("malformed trace line: %s", line);
                end
            end
            $fclose(fd);
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic load_weights();
        for (int o = 0; o < CH_OUT; o++) begin
            for (int i = 0; i < CH_IN; i++) begin
                for (int k = 0; k < KSIZE * KSIZE; k++) begin
                    @(negedge clk);
                    weight_wr.en    = 1'b1;
                    weight_wr.och   = OCH_W'(o);
                    weight_wr.ich   = ICH_W'(i);
                    weight_wr.tap   = TAP_W'(k);
                    weight_wr.value = 8'(wgt[o][i][k]);
                end
            end
        end
        @(negedge clk);
        weight_wr = '0;
    endtask

    task automatic send_frame(input int f, input bit gaps);
        int gap;
        int row;
        int col;
        for (int k = 0; k < NOUT; k++) begin
            exp_q.push_back(exp_feat[f][k]);
        end
        out_count  = 0;
        busy_count = 0;
        for (int k = 0; k < NPIX; k++) begin
            row = k / IMG_W;
            col = k % IMG_W;
            if (gaps) begin
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clk);
            end
            in_valid = 1'b1;
            for (int i = 0; i < CH_IN; i++) begin
                in_pixel[i] = 8'(pix[f][k][i]);
            end
            if (row >= KSIZE - 1 && col >= KSIZE - 1) begin
                trig_q.push_back(cycle_cnt + 1);
            end
            @(negedge clk);
            in_valid = 1'b0;
            // A complete window starts the fold one edge later
            if (row >= KSIZE - 1 && col >= KSIZE - 1) begin
                @(negedge clk);
                check_value("busy", busy, 1);
                while (busy) @(negedge clk);
            end
        end
        while (exp_q.size() != 0) @(negedge clk);
        repeat (LATENCY + 2) @(negedge clk);
        check_value("out_valid pulses", out_count, NOUT);
        check_value("busy windows", busy_count, NOUT);
    endtask

    // ==================================================
    // Output monitor, sampled on the falling edge
    // ==================================================
    always @(negedge clk) begin
        feature_t exp_v;
        int       trig;
        if (rst_n) begin
            if (out_valid) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("out_valid pulse at %0t ns with no result expected", $time);
                end else begin
                    exp_v = exp_q.pop_front();
                    for (int o = 0; o < CH_OUT; o++) begin
                        check_value($sformatf("out_feature[%0d]", o),
                                    $signed(out_feature[o]), $signed(exp_v[o]));
                    end
                end
                if (trig_q.size() != 0) begin
                    trig = trig_q.pop_front();
                    check_value("out_valid latency", cycle_cnt - trig, LATENCY);
                end
            end
            if (busy) begin
                busy_run++;
            end else if (busy_run != 0) begin
                check_value("busy cycles", busy_run, CH_OUT);
                busy_count++;
                busy_run = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        in_valid    = 1'b0;
        in_pixel    = '0;
        weight_wr   = '0;
        cycle_cnt   = 0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        out_count   = 0;
        busy_run    = 0;
        busy_count  = 0;
        seed        = 32'ha43f_d708;
        read_trace();

        @(posedge rst_n);
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("out_valid", out_valid, 0);
        check_value("out_feature", out_feature, 0);
        report_test("reset state");

        load_weights();
        send_frame(0, 1'b0);
        report_test("frame one");
        send_frame(1, 1'b0);
        report_test("frame two with saturation");
        send_frame(0, 1'b1);
        report_test("frame one with random gaps");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: weight_ram.sv
`timescale 1ns/100ps
`default_nettype none

module weight_ram import conv_pkg::*; (
    input  logic             clk,
    input  weight_wr_t       weight_wr,
    input  logic [OCH_W-1:0] och,
    output weights_t         weights
);

    weights_t         mem [CH_OUT];
    logic [TAP_W-1:0] wr_row;
    logic [TAP_W-1:0] wr_col;
    weights_t         rd_q;

    // Tap index runs row major over the kernel
    assign wr_row = TAP_W'(weight_wr.tap / KSIZE);
    assign wr_col = TAP_W'(weight_wr.tap % KSIZE);

    // One byte per write strobe
    always_ff @(posedge clk) begin
        if (weight_wr.en) begin
            mem[weight_wr.och][wr_row][wr_col][weight_wr.ich] <= weight_wr.value;
        end
    end

    // Full kernel of the requested output channel
    always_ff @(posedge clk) begin
        rd_q <= mem[och];
    end

    assign weights = rd_q;

endmodule

`default_nettype wire
